// ==== common/mem_hier_pkg.sv ====
// Memory hierarchy package with widths, cache geometry and controller states
package mem_hier_pkg;

  // Bus widths
  localparam int ADDR_W = 6;   // 64-word address space
  localparam int DATA_W = 16;  // Word size

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // L1 geometry, set picked by the low address bit
  localparam int L1_SETS  = 2;
  localparam int L1_WAYS  = 2;
  localparam int L1_TAG_W = ADDR_W - $clog2(L1_SETS);  // Address bits above the index

  // Backing store depth
  localparam int MEM_WORDS = 64;

  // Access sequencer states
  typedef enum logic [2:0] {
    ST_IDLE      = 3'd0,  // Waiting for an APB access phase
    ST_LOOKUP    = 3'd1,  // Both caches compared, path chosen
    ST_WRITEBACK = 3'd2,  // Dirty L2 victim going out to memory
    ST_FETCH     = 3'd3,  // Read miss data coming in from memory
    ST_FILL      = 3'd4,  // Touch and store pulses to the caches
    ST_DONE      = 3'd5   // PREADY cycle
  } ctrl_state_t;

endpackage

// ==== l1_cache/l1_cache.sv ====
// L1 cache, two sets of two ways with one LRU bit per set, write-through store
`timescale 1ns/1ps

module l1_cache (
  input  logic                clock,
  input  logic                reset,
  input  mem_hier_pkg::addr_t i_addr,
  input  mem_hier_pkg::data_t i_wdata,
  input  logic                i_touch,   // Read hit, refresh LRU only
  input  logic                i_store,   // Write or refill
  output logic                o_hit,
  output mem_hier_pkg::data_t o_rdata
);
  import mem_hier_pkg::*;

  localparam int IDX_W = $clog2(L1_SETS);

  data_t               data_mem [L1_SETS][L1_WAYS];
  logic [L1_TAG_W-1:0] tag_mem  [L1_SETS][L1_WAYS];
  logic [L1_WAYS-1:0]  valid    [L1_SETS];
  logic [L1_SETS-1:0]  lru;       // Way to replace next, per set

  logic [IDX_W-1:0]    set_idx;
  logic [L1_TAG_W-1:0] tag;
  logic                hit0;
  logic                hit1;
  logic                way_sel;   // Way being accessed

  assign set_idx = i_addr[IDX_W-1:0];
  assign tag     = i_addr[ADDR_W-1:IDX_W];

  // Tag compare in both ways
  assign hit0    = valid[set_idx][0] && (tag_mem[set_idx][0] == tag);
  assign hit1    = valid[set_idx][1] && (tag_mem[set_idx][1] == tag);
  assign o_hit   = hit0 || hit1;
  assign o_rdata = hit1 ? data_mem[set_idx][1] : data_mem[set_idx][0];

  // Hit way, else first free way, else the LRU way
  always_comb
  begin
    if (o_hit)
      way_sel = hit1;
    else if (!valid[set_idx][0])
      way_sel = 1'b0;
    else if (!valid[set_idx][1])
      way_sel = 1'b1;
    else
      way_sel = lru[set_idx];
  end

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      for (int s = 0; s < L1_SETS; s++)
        valid[s] <= '0;  // All lines empty
      lru <= '0;
    end
    else if (i_store || (i_touch && o_hit))
    begin
      lru[set_idx] <= ~way_sel;  // Other way becomes the victim
      if (i_store)
        valid[set_idx][way_sel] <= 1'b1;
    end
  end

  // Line contents
  always_ff @(posedge clock)
  begin
    if (i_store)
    begin
      data_mem[set_idx][way_sel] <= i_wdata;
      tag_mem[set_idx][way_sel]  <= tag;
    end
  end

endmodule

// ==== l2_cache/l2_cache.sv ====
// L2 cache, fully associative with age-based LRU, dirty bits and victim reporting
`timescale 1ns/1ps

module l2_cache #(
  parameter int L2_LINES = 8
) (
  input  logic                clock,
  input  logic                reset,
  input  mem_hier_pkg::addr_t i_addr,
  input  mem_hier_pkg::data_t i_wdata,
  input  logic                i_touch,
  input  logic                i_store,
  input  logic                i_dirty,         // Dirty value for the stored line
  output logic                o_hit,
  output mem_hier_pkg::data_t o_rdata,
  output logic                o_victim_dirty,  // Replacement line needs a write-back
  output mem_hier_pkg::addr_t o_victim_addr,
  output mem_hier_pkg::data_t o_victim_data
);
  import mem_hier_pkg::*;

  localparam int IDX_W = $clog2(L2_LINES);
  localparam int AGE_W = $clog2(L2_LINES);
  localparam logic [AGE_W-1:0] AGE_MAX = AGE_W'(L2_LINES - 1);

  addr_t               tag_mem  [L2_LINES];  // Full address as tag
  data_t               data_mem [L2_LINES];
  logic [AGE_W-1:0]    age      [L2_LINES];  // 0 is most recent
  logic [L2_LINES-1:0] valid;
  logic [L2_LINES-1:0] dirty;

  logic                hit_idx_found;
  logic [IDX_W-1:0]    hit_idx;
  logic                has_free;
  logic [IDX_W-1:0]    free_idx;
  logic [IDX_W-1:0]    oldest_idx;
  logic [AGE_W-1:0]    oldest_age;
  logic [IDX_W-1:0]    victim_idx;
  logic [IDX_W-1:0]    acc_idx;     // Line touched or written
  logic [AGE_W-1:0]    acc_age;     // Its age before the access
  logic                update;

  // Associative lookup
  always_comb
  begin
    hit_idx_found = 1'b0;
    hit_idx       = '0;
    for (int i = 0; i < L2_LINES; i++)
    begin
      if (valid[i] && (tag_mem[i] == i_addr))
      begin
        hit_idx_found = 1'b1;
        hit_idx       = IDX_W'(i);
      end
    end
  end

  // Victim choice
  always_comb
  begin
    has_free   = 1'b0;
    free_idx   = '0;
    oldest_idx = '0;
    oldest_age = '0;
    for (int i = L2_LINES - 1; i >= 0; i--)  // Downward so the lowest free line wins
    begin
      if (!valid[i])
      begin
        has_free = 1'b1;
        free_idx = IDX_W'(i);
      end
    end
    for (int i = 0; i < L2_LINES; i++)
    begin
      if (age[i] > oldest_age)
      begin
        oldest_age = age[i];
        oldest_idx = IDX_W'(i);
      end
    end
  end

  assign victim_idx = has_free ? free_idx : oldest_idx;

  assign o_hit          = hit_idx_found;
  assign o_rdata        = data_mem[hit_idx];
  assign o_victim_dirty = valid[victim_idx] && dirty[victim_idx];
  assign o_victim_addr  = tag_mem[victim_idx];
  assign o_victim_data  = data_mem[victim_idx];

  assign acc_idx = o_hit ? hit_idx : victim_idx;
  assign acc_age = o_hit ? age[hit_idx] : AGE_MAX;  // New line counts as oldest
  assign update  = i_store || (i_touch && o_hit);

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      valid <= '0;
      dirty <= '0;
      for (int i = 0; i < L2_LINES; i++)
        age[i] <= '0;
    end
    else if (update)
    begin
      for (int i = 0; i < L2_LINES; i++)
      begin
        if (IDX_W'(i) == acc_idx)
          age[i] <= '0;
        else if (valid[i] && (age[i] < acc_age))  // Lines younger than the accessed one
          age[i] <= age[i] + 1'b1;
      end
      if (i_store)
      begin
        valid[acc_idx] <= 1'b1;
        dirty[acc_idx] <= o_hit ? (dirty[acc_idx] | i_dirty) : i_dirty;
      end
    end
  end

  // Line contents
  always_ff @(posedge clock)
  begin
    if (i_store)
    begin
      tag_mem[acc_idx]  <= i_addr;
      data_mem[acc_idx] <= i_wdata;
    end
  end

endmodule

// ==== logic/main_memory.sv ====
// Main memory, 64-word store behind a fixed-latency request/acknowledge port
`timescale 1ns/1ps

module main_memory #(
  parameter int MEM_LATENCY = 4
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                i_req,    // Held until o_ack
  input  logic                i_we,
  input  mem_hier_pkg::addr_t i_addr,
  input  mem_hier_pkg::data_t i_wdata,
  output logic                o_ack,    // One-cycle pulse
  output mem_hier_pkg::data_t o_rdata   // Valid with o_ack on a read
);
  import mem_hier_pkg::*;

  localparam int CNT_W = $clog2(MEM_LATENCY + 1);

  data_t            mem [MEM_WORDS];
  logic [CNT_W-1:0] cnt;   // Cycles the current request has waited

  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < MEM_WORDS; i++)
        mem[i] <= '0;
      cnt     <= '0;
      o_ack   <= 1'b0;
      o_rdata <= '0;
    end
    else if (o_ack)
    begin
      o_ack <= 1'b0;  // Requester drops i_req now, skip this cycle
      cnt   <= '0;
    end
    else if (i_req)
    begin
      if (cnt == CNT_W'(MEM_LATENCY - 1))
      begin
        o_ack <= 1'b1;
        cnt   <= '0;
        if (i_we)
          mem[i_addr] <= i_wdata;
        else
          o_rdata <= mem[i_addr];
      end
      else
        cnt <= cnt + 1'b1;
    end
  end

endmodule

// ==== logic/cache_ctrl.sv ====
// Cache controller, APB slave that sequences lookups, write-backs, fetches and fills
`timescale 1ns/1ps

module cache_ctrl (
  input  logic                clock,
  input  logic                reset,
  input  logic                i_psel,
  input  logic                i_penable,
  input  logic                i_pwrite,
  input  mem_hier_pkg::addr_t i_paddr,
  input  mem_hier_pkg::data_t i_pwdata,
  input  logic                i_l1_hit,
  input  mem_hier_pkg::data_t i_l1_rdata,
  input  logic                i_l2_hit,
  input  mem_hier_pkg::data_t i_l2_rdata,
  input  logic                i_victim_dirty,
  input  mem_hier_pkg::addr_t i_victim_addr,
  input  mem_hier_pkg::data_t i_victim_data,
  input  logic                i_mem_ack,
  input  mem_hier_pkg::data_t i_mem_rdata,
  output mem_hier_pkg::addr_t o_addr,
  output mem_hier_pkg::data_t o_wdata,
  output logic                o_l1_touch,
  output logic                o_l1_store,
  output logic                o_l2_touch,
  output logic                o_l2_store,
  output logic                o_l2_dirty,
  output logic                o_mem_req,
  output logic                o_mem_we,
  output mem_hier_pkg::addr_t o_mem_addr,
  output mem_hier_pkg::data_t o_mem_wdata,
  output mem_hier_pkg::data_t o_prdata,
  output logic                o_pready,
  output logic                o_hit_l1,
  output logic                o_hit_l2
);
  import mem_hier_pkg::*;

  ctrl_state_t state;
  addr_t       addr_q;    // Transfer address, held for the whole transfer
  data_t       data_q;    // Write data, later the read result
  logic        write_q;
  logic        l1_hit_q;  // Lookup result, kept until the fill
  logic        l2_hit_q;
  logic        fill;

  // Control path
  always_ff @(posedge clock or posedge reset)
  begin
    if (reset)
    begin
      state     <= ST_IDLE;
      write_q   <= 1'b0;
      l1_hit_q  <= 1'b0;
      l2_hit_q  <= 1'b0;
      o_mem_req <= 1'b0;
      o_prdata  <= '0;
      o_hit_l1  <= 1'b0;
      o_hit_l2  <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
          if (i_psel && i_penable)  // Access phase seen
          begin
            write_q <= i_pwrite;
            state   <= ST_LOOKUP;
          end
        ST_LOOKUP:
        begin
          l1_hit_q <= i_l1_hit;
          l2_hit_q <= i_l2_hit;
          if (write_q)  // Writes only need memory when a dirty line is pushed out
            state <= (!i_l2_hit && i_victim_dirty) ? ST_WRITEBACK : ST_FILL;
          else if (i_l1_hit || i_l2_hit)
            state <= ST_FILL;
          else
            state <= i_victim_dirty ? ST_WRITEBACK : ST_FETCH;
        end
        ST_WRITEBACK:
          if (!o_mem_req)
            o_mem_req <= 1'b1;  // Victim goes out first
          else if (i_mem_ack)
          begin
            o_mem_req <= 1'b0;
            state     <= write_q ? ST_FILL : ST_FETCH;
          end
        ST_FETCH:
          if (!o_mem_req)
            o_mem_req <= 1'b1;
          else if (i_mem_ack)
          begin
            o_mem_req <= 1'b0;
            state     <= ST_FILL;
          end
        ST_FILL:
        begin
          o_prdata <= data_q;                 // Held until the next transfer ends
          o_hit_l1 <= l1_hit_q;
          o_hit_l2 <= !l1_hit_q && l2_hit_q;  // L1 takes priority
          state    <= ST_DONE;
        end
        ST_DONE:
          state <= ST_IDLE;
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // Payload path
  always_ff @(posedge clock)
  begin
    if ((state == ST_IDLE) && i_psel && i_penable)
    begin
      addr_q <= i_paddr;
      data_q <= i_pwdata;
    end
    else if ((state == ST_LOOKUP) && !write_q)
      data_q <= i_l1_hit ? i_l1_rdata : i_l2_rdata;  // Overwritten later on a miss
    else if ((state == ST_FETCH) && o_mem_req && i_mem_ack)
      data_q <= i_mem_rdata;

    if (!o_mem_req && (state == ST_WRITEBACK))
    begin
      o_mem_we    <= 1'b1;
      o_mem_addr  <= i_victim_addr;
      o_mem_wdata <= i_victim_data;
    end
    else if (!o_mem_req && (state == ST_FETCH))
    begin
      o_mem_we   <= 1'b0;
      o_mem_addr <= addr_q;
    end
  end

  // Cache commands, one cycle in FILL
  assign fill       = (state == ST_FILL);
  assign o_l1_touch = fill && !write_q && l1_hit_q;
  assign o_l2_touch = fill && !write_q && !l1_hit_q && l2_hit_q;
  assign o_l1_store = fill && (write_q || !l1_hit_q);                // Write-through or refill
  assign o_l2_store = fill && (write_q || (!l1_hit_q && !l2_hit_q));
  assign o_l2_dirty = write_q;  // Fetched lines enter clean

  assign o_addr   = addr_q;
  assign o_wdata  = data_q;
  assign o_pready = (state == ST_DONE);

endmodule

// ==== logic/hier_top.sv ====
// Memory hierarchy top, APB slave in front of L1, L2 and main memory
`timescale 1ns/1ps

module hier_top #(
  parameter int MEM_LATENCY = 4,  // Memory request to acknowledge, in cycles
  parameter int L2_LINES    = 8   // Fully associative L2 depth
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                i_psel,
  input  logic                i_penable,
  input  logic                i_pwrite,
  input  mem_hier_pkg::addr_t i_paddr,
  input  mem_hier_pkg::data_t i_pwdata,
  output mem_hier_pkg::data_t o_prdata,
  output logic                o_pready,
  output logic                o_hit_l1,   // Transfer served by L1
  output logic                o_hit_l2    // Transfer served by L2
);
  import mem_hier_pkg::*;

  addr_t addr;          // Registered request address to both caches
  data_t wdata;         // Store data to both caches
  data_t l1_rdata;
  data_t l2_rdata;
  logic  l1_hit;
  logic  l2_hit;
  logic  l1_touch;
  logic  l1_store;
  logic  l2_touch;
  logic  l2_store;
  logic  l2_dirty;      // Dirty value for an L2 store
  logic  victim_dirty;
  addr_t victim_addr;
  data_t victim_data;
  logic  mem_req;
  logic  mem_we;
  logic  mem_ack;
  addr_t mem_addr;
  data_t mem_wdata;
  data_t mem_rdata;

  cache_ctrl u_ctrl (
    .clock          (clock),
    .reset          (reset),
    .i_psel         (i_psel),
    .i_penable      (i_penable),
    .i_pwrite       (i_pwrite),
    .i_paddr        (i_paddr),
    .i_pwdata       (i_pwdata),
    .i_l1_hit       (l1_hit),
    .i_l1_rdata     (l1_rdata),
    .i_l2_hit       (l2_hit),
    .i_l2_rdata     (l2_rdata),
    .i_victim_dirty (victim_dirty),
    .i_victim_addr  (victim_addr),
    .i_victim_data  (victim_data),
    .i_mem_ack      (mem_ack),
    .i_mem_rdata    (mem_rdata),
    .o_addr         (addr),
    .o_wdata        (wdata),
    .o_l1_touch     (l1_touch),
    .o_l1_store     (l1_store),
    .o_l2_touch     (l2_touch),
    .o_l2_store     (l2_store),
    .o_l2_dirty     (l2_dirty),
    .o_mem_req      (mem_req),
    .o_mem_we       (mem_we),
    .o_mem_addr     (mem_addr),
    .o_mem_wdata    (mem_wdata),
    .o_prdata       (o_prdata),
    .o_pready       (o_pready),
    .o_hit_l1       (o_hit_l1),
    .o_hit_l2       (o_hit_l2)
  );

  l1_cache u_l1 (
    .clock   (clock),
    .reset   (reset),
    .i_addr  (addr),
    .i_wdata (wdata),
    .i_touch (l1_touch),
    .i_store (l1_store),
    .o_hit   (l1_hit),
    .o_rdata (l1_rdata)
  );

  l2_cache #(.L2_LINES(L2_LINES)) u_l2 (
    .clock          (clock),
    .reset          (reset),
    .i_addr         (addr),
    .i_wdata        (wdata),
    .i_touch        (l2_touch),
    .i_store        (l2_store),
    .i_dirty        (l2_dirty),
    .o_hit          (l2_hit),
    .o_rdata        (l2_rdata),
    .o_victim_dirty (victim_dirty),
    .o_victim_addr  (victim_addr),
    .o_victim_data  (victim_data)
  );

  main_memory #(.MEM_LATENCY(MEM_LATENCY)) u_mem (
    .clock   (clock),
    .reset   (reset),
    .i_req   (mem_req),
    .i_we    (mem_we),
    .i_addr  (mem_addr),
    .i_wdata (mem_wdata),
    .o_ack   (mem_ack),
    .o_rdata (mem_rdata)
  );

endmodule

// ==== tests/hier_top_sva.sv ====
// APB handshake and hit flag assertions, bound into the hierarchy top
`timescale 1ns/1ps

module hier_top_sva (
  input logic clock,
  input logic reset,
  input logic i_psel,
  input logic i_penable,
  input logic i_pready,
  input logic i_hit_l1,
  input logic i_hit_l2
);

  // PREADY only inside an access phase
  pready_in_access: assert property (
    @(posedge clock) disable iff (reset) i_pready |-> (i_psel && i_penable)
  ) else $error("o_pready high outside an APB access phase");

  pready_single_cycle: assert property (
    @(posedge clock) disable iff (reset) i_pready |=> !i_pready
  ) else $error("o_pready high for two cycles in a row");  // One completion per transfer

  // A transfer is served by one level at most
  hit_flags_exclusive: assert property (
    @(posedge clock) disable iff (reset) !(i_hit_l1 && i_hit_l2)
  ) else $error("L1 and L2 hit flags high together");

endmodule

bind hier_top hier_top_sva u_sva (
  .clock     (clock),
  .reset     (reset),
  .i_psel    (i_psel),
  .i_penable (i_penable),
  .i_pready  (o_pready),
  .i_hit_l1  (o_hit_l1),
  .i_hit_l2  (o_hit_l2)
);

// ==== tests/tb_hier_top.sv ====
// Testbench for the memory hierarchy, replays golden APB transfers and checks data and hit flags
`timescale 1ns/1ps

module tb_hier_top;
  import mem_hier_pkg::*;

  localparam int MEM_LATENCY  = 4;
  localparam int CLK_PERIOD   = 4;    // ns
  localparam int RESET_CYCLES = 8;
  localparam int MAX_XFERS    = 128;  // Golden table capacity

  logic  clock = 1'b0;
  logic  reset;
  logic  psel;
  logic  penable;
  logic  pwrite;
  addr_t paddr;
  data_t pwdata;
  data_t prdata;
  logic  pready;
  logic  hit_l1;
  logic  hit_l2;

  // Golden table, one entry per transfer
  logic  xfer_write [MAX_XFERS];
  addr_t xfer_addr  [MAX_XFERS];
  data_t xfer_wdata [MAX_XFERS];
  data_t exp_data   [MAX_XFERS];
  logic  exp_l1     [MAX_XFERS];
  logic  exp_l2     [MAX_XFERS];
  int    xfer_group [MAX_XFERS];
  int    num_xfers;
  int    err_count;
  int    timeout_ns;
  logic  loaded = 1'b0;  // Releases the watchdog
  logic  golden_ok;
  int    cur_group;
  int    group_n;
  int    group_e;
  data_t got_data;
  logic  got_l1;
  logic  got_l2;

  hier_top #(.MEM_LATENCY(MEM_LATENCY)) dut0 (
    .clock     (clock),
    .reset     (reset),
    .i_psel    (psel),
    .i_penable (penable),
    .i_pwrite  (pwrite),
    .i_paddr   (paddr),
    .i_pwdata  (pwdata),
    .o_prdata  (prdata),
    .o_pready  (pready),
    .o_hit_l1  (hit_l1),
    .o_hit_l2  (hit_l2)
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  function automatic string group_name(input int g);
    case (g)
      1: return "cold read and reread";
      2: return "write then read";
      3: return "L1 set conflict";
      4: return "L2 overflow and write-back";
      5: return "mixed traffic after evictions";
      default: return "unnamed";
    endcase
  endfunction

  // Golden lines: "# ..." comment, "G n" group start, or a transfer
  task automatic load_golden(output logic ok);
    int          fd;
    int          code;
    int          c;
    int          grp;
    logic [7:0]  ch;
    logic [15:0] f_addr;
    logic [15:0] f_wdata;
    logic [15:0] f_rdata;
    logic [15:0] f_l1;
    logic [15:0] f_l2;
    logic        done;
    ok        = 1'b0;
    num_xfers = 0;
    grp       = 0;
    done      = 1'b0;
    fd = $fopen("tests/hier_golden.txt", "r");
    if (fd == 0)
      $display("Could not open the golden file tests/hier_golden.txt");
    else
    begin
      ok = 1'b1;
      while (!done)
      begin
        code = $fscanf(fd, " %c", ch);
        if (code != 1)
          done = 1'b1;  // End of file
        else if (ch == "#")
        begin
          c = $fgetc(fd);
          while ((c != 10) && (c != -1))  // Up to the newline
            c = $fgetc(fd);
        end
        else if (ch == "G")
          code = $fscanf(fd, "%d", grp);
        else
        begin
          code = $fscanf(fd, "%h %h %h %h %h", f_addr, f_wdata, f_rdata, f_l1, f_l2);
          if ((code != 5) || ((ch != "R") && (ch != "W")) || (num_xfers >= MAX_XFERS))
          begin
            $display("Golden file line after transfer %0d is malformed", num_xfers);
            ok   = 1'b0;
            done = 1'b1;
          end
          else
          begin
            xfer_write[num_xfers] = (ch == "W");
            xfer_addr[num_xfers]  = f_addr[ADDR_W-1:0];
            xfer_wdata[num_xfers] = f_wdata;
            exp_data[num_xfers]   = f_rdata;
            exp_l1[num_xfers]     = f_l1[0];
            exp_l2[num_xfers]     = f_l2[0];
            xfer_group[num_xfers] = grp;
            num_xfers++;
          end
        end
      end
      $fclose(fd);
      if (ok && (num_xfers == 0))
      begin
        $display("Golden file holds no transfers");
        ok = 1'b0;
      end
    end
  endtask

  // One APB transfer, called and returning on a falling edge
  task automatic apb_transfer(input logic write, input addr_t addr, input data_t wdata,
                              output data_t rdata, output logic l1, output logic l2);
    psel    = 1'b1;  // Setup phase
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clock);
    penable = 1'b1;  // Access phase
    @(negedge clock);
    while (!pready)
      @(negedge clock);
    rdata = prdata;
    l1    = hit_l1;
    l2    = hit_l2;
    @(negedge clock);  // Transfer completed on the last rising edge
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic check_result(input int idx, input data_t rdata, input logic l1,
                              input logic l2);
    if (rdata !== exp_data[idx])
    begin
      $display("[FAIL] t=%0d ns: transfer %0d %s 0x%02h returned data 0x%04h, expected 0x%04h",
               $time, idx, xfer_write[idx] ? "W" : "R", xfer_addr[idx], rdata, exp_data[idx]);
      err_count++;
      group_e++;
    end
    if ((l1 !== exp_l1[idx]) || (l2 !== exp_l2[idx]))
    begin
      $display("[FAIL] t=%0d ns: transfer %0d %s 0x%02h hit flags L1=%b L2=%b, expected %b %b",
               $time, idx, xfer_write[idx] ? "W" : "R", xfer_addr[idx], l1, l2,
               exp_l1[idx], exp_l2[idx]);
      err_count++;
      group_e++;
    end
  endtask

  task automatic report_group(input int g, input int n, input int e);
    $display("Group %0d (%s): %0d transfers, %0d errors", g, group_name(g), n, e);
  endtask

  // Watchdog sized from the number of transfers
  initial
  begin
    wait (loaded);
    #(timeout_ns);
    $display("Timeout: transfers still pending after %0d ns", timeout_ns);
    $display("Test failed");
    $finish;
  end

  initial
  begin
    reset     = 1'b1;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    err_count = 0;
    load_golden(golden_ok);
    if (!golden_ok)
    begin
      $display("Test failed");
      $finish;
    end
    else
    begin
      timeout_ns = (RESET_CYCLES + num_xfers * (2 * MEM_LATENCY + 10)) * CLK_PERIOD;
      loaded     = 1'b1;
      repeat (RESET_CYCLES) @(negedge clock);
      reset = 1'b0;
      @(negedge clock);
      cur_group = xfer_group[0];
      group_n   = 0;
      group_e   = 0;
      for (int i = 0; i < num_xfers; i++)
      begin
        if (xfer_group[i] != cur_group)  // Previous group finished
        begin
          report_group(cur_group, group_n, group_e);
          cur_group = xfer_group[i];
          group_n   = 0;
          group_e   = 0;
        end
        apb_transfer(xfer_write[i], xfer_addr[i], xfer_wdata[i], got_data, got_l1, got_l2);
        check_result(i, got_data, got_l1, got_l2);
        group_n++;
      end
      report_group(cur_group, group_n, group_e);
      $display("Summary: %0d transfers checked, %0d errors", num_xfers, err_count);
      if (err_count == 0)
        $display("Test completed successfully");
      else
        $display("Test failed");
      $finish;
    end
  end

endmodule

// ==== tests/hier_golden.txt ====
# Columns: op (R or W), address, write data, expected read data, expected L1 hit, expected L2 hit
# Values are hex; a line "G n" starts test group n
G 1
R 05 0000 0000 0 0
R 05 0000 0000 1 0
G 2
W 0A 1234 1234 0 0
R 0A 0000 1234 1 0
G 3
W 10 A001 A001 0 0
W 20 B002 B002 0 0
R 0A 0000 1234 0 1
R 10 0000 A001 0 1
R 0A 0000 1234 1 0
G 4
W 31 C031 C031 0 0
W 33 C033 C033 0 0
W 35 C035 C035 0 0
W 37 C037 C037 0 0
W 39 C039 C039 0 0
W 3B C03B C03B 0 0
W 3D C03D C03D 0 0
W 3F C03F C03F 0 0
W 2F C02F C02F 0 0
R 31 0000 C031 0 0
G 5
R 0A 0000 1234 1 0
R 20 0000 B002 0 0
W 0A 5A5A 5A5A 1 0
R 33 0000 C033 0 0
R 2F 0000 C02F 0 1
W 2F 1111 1111 1 0
R 05 0000 0000 0 0
R 3B 0000 C03B 0 0
R 2F 0000 1111 0 1
R 0A 0000 5A5A 1 0
R 10 0000 A001 0 0
R 3F 0000 C03F 0 0
R 37 0000 C037 0 0
R 20 0000 B002 0 0
R 0A 0000 5A5A 0 0

// ==== sources.f ====
common/mem_hier_pkg.sv
l1_cache/l1_cache.sv
l2_cache/l2_cache.sv
logic/main_memory.sv
logic/cache_ctrl.sv
logic/hier_top.sv
tests/hier_top_sva.sv
tests/tb_hier_top.sv

// ==== run.sh ====
#!/bin/sh
# Build the memory hierarchy testbench with Verilator, run it and search for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_hier_top -f sources.f -o tb_hier_top_sim \
  || { echo "Build failed"; exit 1; }
out=$(./obj_dir/tb_hier_top_sim 2>&1)
echo "$out"
echo "$out" | grep -q "Test completed successfully" && echo "PASS" && exit 0 \
  || { echo "FAIL"; exit 1; }
